//--- design/core_pkg.sv
/*
 Core-wide widths and vector types.
 Only 32-bit words are supported. Addresses are byte addresses.
 Word accesses are expected to be aligned.
 */
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;                 // data path width

    typedef logic [XLEN-1:0] xlen_t;          // register and bus data word
    typedef logic [31:0]     addr_t;          // byte address
    typedef logic [31:0]     inst_t;          // raw instruction word
    typedef logic [4:0]      reg_idx_t;       // x0..x31

    // owner of a granted read on the shared memory bus
    typedef enum logic {
        FETCH = 1'b0,
        DATA  = 1'b1
    } bus_owner_t;

endpackage

`default_nettype wire

//--- design/isa_pkg.sv
/*
 Encodings for the supported RV32I subset.
 Opcodes outside opcode_t decode as no-ops in the execute unit.
 */
`default_nettype none

package isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B          // lui
    } alu_op_t;

    typedef logic [2:0] funct3_t;

    // branch compare select
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    // alu select, shared by OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_WORD    = 3'b010;   // lw / sw

endpackage

`default_nettype wire

//--- design/gpr.sv
/*
 General-purpose registers x1..x31, cleared on reset.
 x0 reads as zero and ignores writes.
 Reads are combinational and see a write only after its clock edge.
 */
`timescale 1ns/1ns
`default_nettype none

module gpr (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      we_i,
    input  wire  core_pkg::reg_idx_t waddr_i,
    input  wire  core_pkg::xlen_t    wdata_i,
    input  wire  core_pkg::reg_idx_t raddr1_i,
    output core_pkg::xlen_t          rdata1_o,
    input  wire  core_pkg::reg_idx_t raddr2_i,
    output core_pkg::xlen_t          rdata2_o
);
    import core_pkg::*;

    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- design/ifu_prefetch.sv
/*
 Instruction fetch master with a small prefetch FIFO.
 PREFETCH_DEPTH must be a power of two, 2 or more.
 Assumes read data returns exactly one cycle after grant.
 A redirect empties the FIFO and drops a fetch granted in that cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module ifu_prefetch #(
    parameter core_pkg::addr_t RESET_PC       = 32'h0000_0000,
    parameter int              PREFETCH_DEPTH = 4
) (
    input  wire                   clk,
    input  wire                   reset_i,
    output logic                  bus_req_o,
    output core_pkg::addr_t       bus_addr_o,
    input  wire                   bus_gnt_i,
    input  wire                   bus_rvalid_i,
    input  wire  core_pkg::inst_t bus_rdata_i,
    output logic                  inst_valid_o,
    output core_pkg::inst_t       inst_o,
    output core_pkg::addr_t       inst_pc_o,
    input  wire                   inst_take_i,
    input  wire                   redirect_i,
    input  wire  core_pkg::addr_t redirect_pc_i
);
    import core_pkg::*;

    localparam int PW = $clog2(PREFETCH_DEPTH);

    inst_t         inst_buf [PREFETCH_DEPTH];
    addr_t         pc_buf   [PREFETCH_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    addr_t         fetch_addr;
    addr_t         resp_pc;                   // pc of the fetch in flight
    logic          inflight;
    logic          discard;
    logic          room;
    logic          granted;
    logic          push;
    logic          pop;

    // an in-flight fetch already owns one free slot
    assign room       = (int'(count) + int'(inflight)) < PREFETCH_DEPTH;
    assign bus_req_o  = !reset_i && room;     // first fetch right after reset
    assign bus_addr_o = fetch_addr;
    assign granted    = bus_req_o && bus_gnt_i;

    assign push = bus_rvalid_i && !discard && !redirect_i;
    assign pop  = inst_take_i && inst_valid_o;

    assign inst_valid_o = (count != '0);
    assign inst_o       = inst_buf[rd_ptr];
    assign inst_pc_o    = pc_buf[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_addr <= RESET_PC;
            inflight   <= 1'b0;
            discard    <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
        end else begin
            inflight <= granted;
            discard  <= granted && redirect_i;   // stale target, drop its data
            if (redirect_i) begin
                fetch_addr <= redirect_pc_i;
                wr_ptr     <= '0;
                rd_ptr     <= '0;
                count      <= '0;
            end else begin
                if (granted) fetch_addr <= fetch_addr + 32'd4;
                if (push) wr_ptr <= wr_ptr + 1'b1;
                if (pop) rd_ptr <= rd_ptr + 1'b1;
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (granted) resp_pc <= fetch_addr;
        if (push) begin
            inst_buf[wr_ptr] <= bus_rdata_i;
            pc_buf[wr_ptr]   <= resp_pc;
        end
    end

endmodule

`default_nettype wire

//--- design/lsu.sv
/*
 Load/store master, one aligned word access at a time.
 start_i is only honoured while idle.
 done_o pulses at grant for a store and at the read response for a load.
 */
`timescale 1ns/1ns
`default_nettype none

module lsu (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   start_i,
    input  wire                   we_i,
    input  wire  core_pkg::addr_t addr_i,
    input  wire  core_pkg::xlen_t wdata_i,
    output logic                  done_o,
    output core_pkg::xlen_t       rdata_o,
    output logic                  bus_req_o,
    output logic                  bus_we_o,
    output core_pkg::addr_t       bus_addr_o,
    output core_pkg::xlen_t       bus_wdata_o,
    input  wire                   bus_gnt_i,
    input  wire                   bus_rvalid_i,
    input  wire  core_pkg::xlen_t bus_rdata_i
);
    import core_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, RESP} state_t;

    state_t state;
    logic   we_q;
    addr_t  addr_q;
    xlen_t  wdata_q;

    // request held stable from the latched access until granted
    assign bus_req_o   = (state == REQ);
    assign bus_we_o    = we_q;
    assign bus_addr_o  = addr_q;
    assign bus_wdata_o = wdata_q;

    assign done_o  = (state == REQ && bus_gnt_i && we_q) || (state == RESP && bus_rvalid_i);
    assign rdata_o = bus_rdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start_i) state <= REQ;
                REQ:     if (bus_gnt_i) state <= we_q ? IDLE : RESP;
                RESP:    if (bus_rvalid_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            we_q    <= we_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
/*
 Two-master arbiter for the single memory bus.
 The data master has fixed priority over fetch.
 Read responses are steered by the owner of the last granted read,
 which relies on the fixed one-cycle read latency.
 */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   f_req_i,
    input  wire  core_pkg::addr_t f_addr_i,
    output logic                  f_gnt_o,
    output logic                  f_rvalid_o,
    output core_pkg::inst_t       f_rdata_o,
    input  wire                   d_req_i,
    input  wire                   d_we_i,
    input  wire  core_pkg::addr_t d_addr_i,
    input  wire  core_pkg::xlen_t d_wdata_i,
    output logic                  d_gnt_o,
    output logic                  d_rvalid_o,
    output core_pkg::xlen_t       d_rdata_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output core_pkg::addr_t       mem_addr_o,
    output core_pkg::xlen_t       mem_wdata_o,
    input  wire                   mem_gnt_i,
    input  wire                   mem_rvalid_i,
    input  wire  core_pkg::xlen_t mem_rdata_i
);
    import core_pkg::*;

    bus_owner_t owner;          // master driving the bus this cycle
    bus_owner_t owner_q;        // master of the read granted last cycle

    assign owner = d_req_i ? DATA : FETCH;

    assign mem_req_o   = f_req_i || d_req_i;
    assign mem_we_o    = d_req_i && d_we_i;
    assign mem_addr_o  = (owner == DATA) ? d_addr_i : f_addr_i;
    assign mem_wdata_o = d_wdata_i;          // fetch never writes

    assign d_gnt_o = d_req_i && mem_gnt_i;
    assign f_gnt_o = f_req_i && (owner == FETCH) && mem_gnt_i;

    assign f_rvalid_o = mem_rvalid_i && (owner_q == FETCH);
    assign d_rvalid_o = mem_rvalid_i && (owner_q == DATA);
    assign f_rdata_o  = mem_rdata_i;
    assign d_rdata_o  = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q <= FETCH;
        end else if (mem_req_o && mem_gnt_i && !mem_we_o) begin
            owner_q <= owner;
        end
    end

endmodule

`default_nettype wire

//--- design/exu.sv
/*
 Decode and execute, one instruction at a time.
 ALU ops, LUI and JAL retire in the cycle they are taken.
 Loads and stores park in MEM_WAIT until the LSU reports done.
 Unsupported opcodes and funct3 values retire without effect.
 */
`timescale 1ns/1ns
`default_nettype none

module exu (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      inst_valid_i,
    input  wire  core_pkg::inst_t    inst_i,
    input  wire  core_pkg::addr_t    inst_pc_i,
    output logic                     inst_take_o,
    output logic                     redirect_o,
    output core_pkg::addr_t          redirect_pc_o,
    output core_pkg::reg_idx_t       rs1_o,
    output core_pkg::reg_idx_t       rs2_o,
    input  wire  core_pkg::xlen_t    rs1_data_i,
    input  wire  core_pkg::xlen_t    rs2_data_i,
    output logic                     wb_we_o,
    output core_pkg::reg_idx_t       wb_rd_o,
    output core_pkg::xlen_t          wb_data_o,
    output logic                     lsu_start_o,
    output logic                     lsu_we_o,
    output core_pkg::addr_t          lsu_addr_o,
    output core_pkg::xlen_t          lsu_wdata_o,
    input  wire                      lsu_done_i,
    input  wire  core_pkg::xlen_t    lsu_rdata_i
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef enum logic {EXEC, MEM_WAIT} state_t;

    state_t   state;
    reg_idx_t rd_q;             // load destination while waiting
    logic     load_q;
    opcode_t  opcode;
    funct3_t  funct3;
    reg_idx_t rd;
    xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t  alu_op;
    xlen_t    alu_b;
    xlen_t    alu_res;
    logic     alu_we;
    logic     is_mem;
    logic     taken;
    logic     take;

    assign opcode = opcode_t'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        alu_op = ALU_ADD;
        alu_b  = imm_i;
        alu_we = 1'b0;
        case (opcode)
            OP_IMM, OP: begin
                alu_we = 1'b1;
                if (opcode == OP) alu_b = rs2_data_i;
                case (funct3)
                    F3_ADD_SUB: alu_op = (opcode == OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_we = 1'b0;       // slt and shifts not in subset
                endcase
            end
            LUI: begin
                alu_op = ALU_PASS_B;
                alu_b  = imm_u;
                alu_we = 1'b1;
            end
            default: alu_we = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = rs1_data_i - alu_b;
            ALU_AND:    alu_res = rs1_data_i & alu_b;
            ALU_OR:     alu_res = rs1_data_i | alu_b;
            ALU_XOR:    alu_res = rs1_data_i ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = rs1_data_i + alu_b;
        endcase
    end

    // branch resolution
    assign taken = (opcode == JAL) ||
                   (opcode == BRANCH && funct3 == F3_BEQ && rs1_data_i == rs2_data_i) ||
                   (opcode == BRANCH && funct3 == F3_BNE && rs1_data_i != rs2_data_i);

    assign take          = (state == EXEC) && inst_valid_i;
    assign inst_take_o   = take;
    assign redirect_o    = take && taken;
    assign redirect_pc_o = inst_pc_i + ((opcode == JAL) ? imm_j : imm_b);

    assign is_mem      = (opcode == LOAD || opcode == STORE) && funct3 == F3_WORD;
    assign lsu_start_o = take && is_mem;
    assign lsu_we_o    = (opcode == STORE);
    assign lsu_addr_o  = rs1_data_i + ((opcode == STORE) ? imm_s : imm_i);
    assign lsu_wdata_o = rs2_data_i;

    // x0 writes never leave the core
    always_comb begin
        wb_we_o   = 1'b0;
        wb_rd_o   = rd;
        wb_data_o = alu_res;
        if (state == MEM_WAIT) begin
            wb_we_o   = lsu_done_i && load_q && (rd_q != '0);
            wb_rd_o   = rd_q;
            wb_data_o = lsu_rdata_i;
        end else if (take && opcode == JAL) begin
            wb_we_o   = (rd != '0);
            wb_data_o = inst_pc_i + 32'd4;          // link address
        end else if (take) begin
            wb_we_o   = alu_we && (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= EXEC;
        end else begin
            case (state)
                EXEC:     if (lsu_start_o) state <= MEM_WAIT;
                MEM_WAIT: if (lsu_done_i) state <= EXEC;
                default:  state <= EXEC;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_start_o) begin
            rd_q   <= rd;
            load_q <= (opcode == LOAD);
        end
    end

endmodule

`default_nettype wire

//--- design/core_top.sv
/*
 Core top level. Memory is external and shared by fetch and data.
 Read data must return one cycle after grant.
 wb_* mirrors every register write except writes to x0.
 */
`timescale 1ns/1ns
`default_nettype none

module core_top #(
    parameter core_pkg::addr_t RESET_PC       = 32'h0000_0000,
    parameter int              PREFETCH_DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      reset_i,
    output wire                      mem_req_o,
    output wire                      mem_we_o,
    output wire  core_pkg::addr_t    mem_addr_o,
    output wire  core_pkg::xlen_t    mem_wdata_o,
    input  wire                      mem_gnt_i,
    input  wire                      mem_rvalid_i,
    input  wire  core_pkg::xlen_t    mem_rdata_i,
    output wire                      wb_valid_o,
    output wire  core_pkg::reg_idx_t wb_rd_o,
    output wire  core_pkg::xlen_t    wb_data_o
);
    import core_pkg::*;

    // fetch master
    wire           f_req, f_gnt, f_rvalid;
    wire addr_t    f_addr;
    wire inst_t    f_rdata;
    wire           inst_valid, inst_take, redirect;
    wire inst_t    inst;
    wire addr_t    inst_pc, redirect_pc;

    // data master
    wire           d_req, d_we, d_gnt, d_rvalid;
    wire addr_t    d_addr;
    wire xlen_t    d_wdata, d_rdata;
    wire           lsu_start, lsu_we, lsu_done;
    wire addr_t    lsu_addr;
    wire xlen_t    lsu_wdata, lsu_rdata;

    wire reg_idx_t rs1, rs2;
    wire xlen_t    rs1_data, rs2_data;

    ifu_prefetch #(
        .RESET_PC      (RESET_PC),
        .PREFETCH_DEPTH(PREFETCH_DEPTH)
    ) u_ifu (
        .clk(clk), .reset_i(reset_i),
        .bus_req_o(f_req), .bus_addr_o(f_addr), .bus_gnt_i(f_gnt),
        .bus_rvalid_i(f_rvalid), .bus_rdata_i(f_rdata),
        .inst_valid_o(inst_valid), .inst_o(inst), .inst_pc_o(inst_pc),
        .inst_take_i(inst_take), .redirect_i(redirect), .redirect_pc_i(redirect_pc)
    );

    lsu u_lsu (
        .clk(clk), .reset_i(reset_i),
        .start_i(lsu_start), .we_i(lsu_we), .addr_i(lsu_addr), .wdata_i(lsu_wdata),
        .done_o(lsu_done), .rdata_o(lsu_rdata),
        .bus_req_o(d_req), .bus_we_o(d_we), .bus_addr_o(d_addr), .bus_wdata_o(d_wdata),
        .bus_gnt_i(d_gnt), .bus_rvalid_i(d_rvalid), .bus_rdata_i(d_rdata)
    );

    bus_arbiter u_arb (
        .clk(clk), .reset_i(reset_i),
        .f_req_i(f_req), .f_addr_i(f_addr), .f_gnt_o(f_gnt),
        .f_rvalid_o(f_rvalid), .f_rdata_o(f_rdata),
        .d_req_i(d_req), .d_we_i(d_we), .d_addr_i(d_addr), .d_wdata_i(d_wdata),
        .d_gnt_o(d_gnt), .d_rvalid_o(d_rvalid), .d_rdata_o(d_rdata),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
        .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
    );

    exu u_exu (
        .clk(clk), .reset_i(reset_i),
        .inst_valid_i(inst_valid), .inst_i(inst), .inst_pc_i(inst_pc),
        .inst_take_o(inst_take), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .wb_we_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .lsu_start_o(lsu_start), .lsu_we_o(lsu_we), .lsu_addr_o(lsu_addr),
        .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata)
    );

    gpr u_gpr (
        .clk(clk), .reset_i(reset_i),
        .we_i(wb_valid_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o),
        .raddr1_i(rs1), .rdata1_o(rs1_data),
        .raddr2_i(rs2), .rdata2_o(rs2_data)
    );

endmodule

`default_nettype wire

//--- tb/core_checker.sv
/*
 Compares write-backs and granted bus writes with queued expected events, in order.
 Each observed event consumes one expected event. Events during reset are ignored.
 An event with nothing pending counts as stray.
 */
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input  wire        clk,
    input  wire        reset_i,
    input  wire        wb_valid_i,
    input  wire [4:0]  wb_rd_i,
    input  wire [31:0] wb_data_i,
    input  wire        mem_req_i,
    input  wire        mem_we_i,
    input  wire        mem_gnt_i,
    input  wire [31:0] mem_addr_i,
    input  wire [31:0] mem_wdata_i,
    output int         tests_done_o,
    output int         tests_ok_o,
    output int         tests_bad_o,
    output int         stray_o
);
    bit          exp_store[$];
    logic [31:0] exp_a[$];
    logic [31:0] exp_b[$];
    int          test_num;
    int          n_expected;
    int          n_seen;
    int          n_wrong;
    int          n_done = 0;
    int          n_ok = 0;
    int          n_bad = 0;
    int          n_stray = 0;

    assign tests_done_o = n_done;
    assign tests_ok_o   = n_ok;
    assign tests_bad_o  = n_bad;
    assign stray_o      = n_stray;

    task automatic push_event(input bit is_store, input logic [31:0] a, input logic [31:0] b);
        exp_store.push_back(is_store);
        exp_a.push_back(a);
        exp_b.push_back(b);
    endtask

    task automatic begin_test(input int num);
        test_num   = num;
        n_expected = exp_store.size();
        n_seen     = 0;
        n_wrong    = 0;
    endtask

    task automatic check_event(input bit is_store, input logic [31:0] a, input logic [31:0] b);
        bit          es;
        logic [31:0] ea;
        logic [31:0] eb;
        if (exp_store.size() == 0) begin
            $display("error at %0t: test %0d %s %h %h with no event pending",
                     $time, test_num, is_store ? "store" : "write-back", a, b);
            n_stray++;
        end else begin
            es = exp_store.pop_front();
            ea = exp_a.pop_front();
            eb = exp_b.pop_front();
            if (es != is_store || ea !== a || eb !== b) begin
                $display("error at %0t: test %0d event %0d got %s %h %h, expected %s %h %h",
                         $time, test_num, n_seen + 1, is_store ? "store" : "write-back", a, b,
                         es ? "store" : "write-back", ea, eb);
                n_wrong++;
            end
            n_seen++;
            if (n_seen == n_expected) begin
                if (n_wrong == 0) begin
                    $display("test %0d ok, %0d events", test_num, n_seen);
                    n_ok++;
                end else begin
                    $display("test %0d bad, %0d of %0d events wrong", test_num, n_wrong, n_seen);
                    n_bad++;
                end
                n_done++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset_i) begin
            if (wb_valid_i) check_event(1'b0, {27'b0, wb_rd_i}, wb_data_i);
            if (mem_req_i && mem_we_i && mem_gnt_i) check_event(1'b1, mem_addr_i, mem_wdata_i);
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_core_top.sv
/*
 Testbench for core_top with a 256-word memory model, so addresses wrap at 1 KiB.
 Grants stall at random from an LFSR. Read data returns one cycle after grant.
 Every program ends in a jump to itself, so the core idles until the next reset.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_core_top;

    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam int          N_TESTS    = 5;
    localparam int          EV_NONE    = 0;
    localparam int          EV_WB      = 1;     // a = rd, b = value
    localparam int          EV_ST      = 2;     // a = address, b = data
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
    logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    logic [31:0] mem [256];
    logic [31:0] lfsr = 32'h602b_e759;
    int          row_test[$];
    logic [31:0] row_inst[$];
    int          row_kind[$];
    logic [31:0] row_a[$];
    logic [31:0] row_b[$];
    int          cur_test;
    bit          table_ready;
    int          tests_done, tests_ok, tests_bad, stray;

    always #(CLK_PERIOD/2) clk = ~clk;

    core_top #(
        .RESET_PC      (RESET_PC),
        .PREFETCH_DEPTH(4)
    ) u_dut (
        .clk(clk), .reset_i(reset_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
        .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    core_checker u_chk (
        .clk(clk), .reset_i(reset_i),
        .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
        .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_gnt_i(mem_gnt_i),
        .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
        .tests_done_o(tests_done), .tests_ok_o(tests_ok), .tests_bad_o(tests_bad),
        .stray_o(stray)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return enc_i(OPC_IMM, 3'b000, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return enc_i(OPC_LOAD, 3'b010, rd, rs1, imm);
    endfunction

    task automatic add_row(input int test, input logic [31:0] inst, input int kind,
                           input logic [31:0] a, input logic [31:0] b);
        row_test.push_back(test);
        row_inst.push_back(inst);
        row_kind.push_back(kind);
        row_a.push_back(a);
        row_b.push_back(b);
    endtask

    task automatic build_table();
        // alu ops, x0 as a target and as a source
        add_row(1, addi(1, 0, 5), EV_WB, 1, 32'h0000_0005);
        add_row(1, addi(2, 0, -3), EV_WB, 2, 32'hffff_fffd);
        add_row(1, enc_u(3, 20'h12345), EV_WB, 3, 32'h1234_5000);
        add_row(1, enc_r(7'h00, 3'b000, 4, 1, 2), EV_WB, 4, 32'h0000_0002);
        add_row(1, enc_r(7'h20, 3'b000, 5, 1, 2), EV_WB, 5, 32'h0000_0008);
        add_row(1, enc_r(7'h00, 3'b111, 6, 1, 2), EV_WB, 6, 32'h0000_0005);
        add_row(1, enc_r(7'h00, 3'b110, 7, 3, 1), EV_WB, 7, 32'h1234_5005);
        add_row(1, enc_r(7'h00, 3'b100, 8, 1, 2), EV_WB, 8, 32'hffff_fff8);
        add_row(1, addi(0, 1, 7), EV_NONE, 0, 0);
        add_row(1, enc_r(7'h00, 3'b000, 9, 0, 1), EV_WB, 9, 32'h0000_0005);
        add_row(1, enc_j(0, 0), EV_NONE, 0, 0);
        // store, load back, preloaded words
        add_row(2, addi(1, 0, 32'h200), EV_WB, 1, 32'h0000_0200);
        add_row(2, addi(2, 0, 32'h7a5), EV_WB, 2, 32'h0000_07a5);
        add_row(2, enc_s(2, 1, 8), EV_ST, 32'h0000_0208, 32'h0000_07a5);
        add_row(2, lw(3, 1, 8), EV_WB, 3, 32'h0000_07a5);
        add_row(2, lw(4, 1, 0), EV_WB, 4, 32'h5a5a_1234);
        add_row(2, lw(5, 1, 4), EV_WB, 5, 32'h1357_9bdf);
        add_row(2, enc_s(5, 1, -4), EV_ST, 32'h0000_01fc, 32'h1357_9bdf);
        add_row(2, enc_r(7'h00, 3'b000, 6, 3, 4), EV_WB, 6, 32'h5a5a_19d9);
        add_row(2, enc_j(0, 0), EV_NONE, 0, 0);
        // taken beq and bne skip ahead
        add_row(3, addi(1, 0, 7), EV_WB, 1, 32'h0000_0007);
        add_row(3, addi(2, 0, 7), EV_WB, 2, 32'h0000_0007);
        add_row(3, enc_b(3'b000, 1, 2, 12), EV_NONE, 0, 0);
        add_row(3, addi(3, 0, 1), EV_NONE, 0, 0);
        add_row(3, addi(3, 0, 2), EV_NONE, 0, 0);
        add_row(3, addi(4, 0, 3), EV_WB, 4, 32'h0000_0003);
        add_row(3, enc_b(3'b001, 1, 4, 8), EV_NONE, 0, 0);
        add_row(3, addi(5, 0, 9), EV_NONE, 0, 0);
        add_row(3, addi(6, 0, 32'h55), EV_WB, 6, 32'h0000_0055);
        add_row(3, enc_j(0, 0), EV_NONE, 0, 0);
        // jal links pc+4, branches that fall through
        add_row(4, addi(1, 0, 1), EV_WB, 1, 32'h0000_0001);
        add_row(4, enc_j(2, 12), EV_WB, 2, 32'h0000_0008);
        add_row(4, addi(3, 0, 32'h11), EV_NONE, 0, 0);
        add_row(4, addi(3, 0, 32'h22), EV_NONE, 0, 0);
        add_row(4, enc_b(3'b000, 1, 0, 8), EV_NONE, 0, 0);
        add_row(4, addi(4, 2, 1), EV_WB, 4, 32'h0000_0009);
        add_row(4, enc_b(3'b001, 1, 1, 8), EV_NONE, 0, 0);
        add_row(4, enc_j(5, 8), EV_WB, 5, 32'h0000_0020);
        add_row(4, addi(6, 0, 1), EV_NONE, 0, 0);
        add_row(4, enc_j(0, 0), EV_NONE, 0, 0);
        // mixed program, data and fetch fight for the bus
        add_row(5, addi(1, 0, 32'h200), EV_WB, 1, 32'h0000_0200);
        add_row(5, lw(2, 1, 0), EV_WB, 2, 32'h5a5a_1234);
        add_row(5, addi(3, 2, 1), EV_WB, 3, 32'h5a5a_1235);
        add_row(5, enc_s(3, 1, 12), EV_ST, 32'h0000_020c, 32'h5a5a_1235);
        add_row(5, lw(4, 1, 12), EV_WB, 4, 32'h5a5a_1235);
        add_row(5, enc_r(7'h00, 3'b100, 5, 4, 2), EV_WB, 5, 32'h0000_0001);
        add_row(5, enc_b(3'b001, 5, 0, 8), EV_NONE, 0, 0);
        add_row(5, enc_s(0, 1, 0), EV_NONE, 0, 0);
        add_row(5, enc_s(5, 1, 16), EV_ST, 32'h0000_0210, 32'h0000_0001);
        add_row(5, enc_u(6, 20'habcde), EV_WB, 6, 32'habcd_e000);
        add_row(5, enc_r(7'h20, 3'b000, 7, 6, 5), EV_WB, 7, 32'habcd_dfff);
        add_row(5, lw(8, 1, 4), EV_WB, 8, 32'h1357_9bdf);
        add_row(5, enc_j(0, 0), EV_NONE, 0, 0);
    endtask

    task automatic load_test(input int t);
        logic [31:0] pc;
        pc = RESET_PC;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[24:0], 7'h7f};                  // opcode 7f decodes as a no-op
        end
        mem[128] = 32'h5a5a_1234;                       // data at 0x200
        mem[129] = 32'h1357_9bdf;
        for (int r = 0; r < row_test.size(); r++) begin
            if (row_test[r] == t) begin
                mem[pc[9:2]] = row_inst[r];
                pc = pc + 32'd4;
                if (row_kind[r] != EV_NONE) begin
                    u_chk.push_event(row_kind[r] == EV_ST, row_a[r], row_b[r]);
                end
            end
        end
        u_chk.begin_test(t);
    endtask

    // memory model, read data one cycle after grant
    always @(posedge clk) begin : mem_model
        logic        rd_fire;
        logic [31:0] rd_word;
        logic        b0;
        logic        b1;
        rd_fire = !reset_i && mem_req_o && mem_gnt_i && !mem_we_o;
        rd_word = mem[mem_addr_o[9:2]];
        if (!reset_i && mem_req_o && mem_gnt_i && mem_we_o) begin
            mem[mem_addr_o[9:2]] = mem_wdata_o;
        end
        lfsr = lfsr_step(lfsr);
        b0   = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1   = lfsr[0];
        #1;
        mem_rvalid_i = rd_fire;
        mem_rdata_i  = rd_fire ? rd_word : 32'h0;
        mem_gnt_i    = b0 | b1;                         // stall only on 00
    end

    initial begin : watchdog
        wait (table_ready);
        #(row_test.size() * 40 * CLK_PERIOD);
        $display("timeout: test %0d never completed", cur_test);
        $display("test failed");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = 32'h0;
        cur_test     = 0;
        build_table();
        table_ready = 1'b1;
        for (int t = 1; t <= N_TESTS; t++) begin
            cur_test = t;
            @(posedge clk);
            #1 reset_i = 1'b1;
            load_test(t);
            repeat (4) @(posedge clk);
            #1 reset_i = 1'b0;
            wait (tests_done == t);
        end
        $display("%0d tests ok, %0d tests bad, %0d stray events", tests_ok, tests_bad, stray);
        if (tests_bad == 0 && stray == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/core_pkg.sv
design/isa_pkg.sv
design/gpr.sv
design/ifu_prefetch.sv
design/lsu.sv
design/bus_arbiter.sv
design/exu.sv
design/core_top.sv
tb/core_checker.sv
tb/tb_core_top.sv
